/* Makefile */
VERILATOR ?= verilator
TB_TOP    ?= tb_pipe_cpu
RTL_TOP   ?= pipe_cpu
FILELIST  ?= pipe_cpu.f
BUILD_DIR ?= obj_dir
PASS_MSG  ?= Regression passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TB_TOP)

sim:
	$(VERILATOR) --binary --timing --assert -f $(FILELIST) \
		--top-module $(TB_TOP) -Mdir $(BUILD_DIR)
	@out=$$(./$(BUILD_DIR)/V$(TB_TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* pipe_cpu.f */
src/pipe_cpu_pkg.sv
src/fetch_stage.sv
src/decode_stage.sv
src/execute_stage.sv
src/memory_stage.sv
src/pipe_cpu.sv
sim/tb_clk_gen.sv
sim/tb_pipe_cpu.sv

/* sim/tb_clk_gen.sv */
module tb_clk_gen #(
    parameter realtime PERIOD = 8ns
) (
    output logic clk_o
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD / 2) clk_o = ~clk_o;
    end

endmodule

/* sim/tb_pipe_cpu.sv */
module tb_pipe_cpu;
    timeunit 1ns;
    timeprecision 1ps;
    import pipe_cpu_pkg::*;

    localparam int         NUM_TESTS = 5;
    localparam logic [11:0] LED      = LED_ADDR[11:0];

    logic  clk;
    logic  rst_n;
    word_t imem_addr;
    word_t imem_rdata;
    word_t ledr;
    word_t pc_debug;
    logic  insn_vld;
    word_t imem [64];
    word_t trace [$];

    tb_clk_gen i_tb_clk_gen (.clk_o(clk));

    pipe_cpu #(.DMEM_WORDS(64)) i_pipe_cpu (
        .clk_i        (clk),
        .rst_ni       (rst_n),
        .imem_addr_o  (imem_addr),
        .imem_rdata_i (imem_rdata),
        .io_ledr_o    (ledr),
        .pc_debug_o   (pc_debug),
        .insn_vld_o   (insn_vld)
    );

    assign imem_rdata = imem[imem_addr[7:2]];

    // Retire log, MEM/WB as it stood before this edge
    always @(posedge clk) begin
        if (rst_n && insn_vld) begin
            trace.push_back(pc_debug);
        end
    end

    // RV32I encoders
    function automatic word_t enc_r(logic [6:0] f7, logic [2:0] f3, logic [4:0] rd,
                                    logic [4:0] rs1, logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic word_t enc_addi(logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic word_t enc_lw(logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
        return {imm, rs1, 3'b010, rd, 7'b0000011};
    endfunction

    function automatic word_t enc_sw(logic [4:0] rs2, logic [4:0] rs1, logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic word_t enc_br(logic ne, logic [4:0] rs1, logic [4:0] rs2,
                                     logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, 2'b00, ne, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic word_t enc_jal(logic [4:0] rd, logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    task automatic report_mismatch(input string msg);
        $display("[FAIL] %0t ns: %s", $time, msg);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic check_word(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            report_mismatch($sformatf("%s: got %08h, expected %08h", what, got, exp));
        end
    endtask

    task automatic check_trace(input word_t exp[$], input string what);
        if (trace.size() != exp.size()) begin
            report_mismatch($sformatf("%s: %0d retires, expected %0d", what,
                                      trace.size(), exp.size()));
        end
        foreach (exp[i]) begin
            check_word(trace[i], exp[i], $sformatf("%s retire %0d", what, i));
        end
    endtask

    // Program words are loaded while reset holds the core
    task automatic load_and_reset(input word_t prog[$]);
        @(posedge clk);
        rst_n <= 1'b0;
        foreach (imem[i]) begin
            imem[i] = (i < prog.size()) ? prog[i] : '0;
        end
        repeat (10) @(posedge clk);
        trace.delete();
        rst_n <= 1'b1;
    endtask

    task automatic wait_retire(input word_t pc);
        while (!(trace.size() > 0 && trace[$] == pc)) begin
            @(negedge clk);
        end
    endtask

    task automatic test_alu_forwarding();
        logic [10:0] a;
        logic [10:0] b;
        word_t       c;
        word_t       d;
        word_t       e;
        a = 11'($urandom);
        b = 11'($urandom);
        load_and_reset('{enc_addi(1, 0, {1'b0, a}), enc_addi(2, 0, {1'b0, b}),
                         enc_r(7'h00, 3'b000, 3, 1, 2), enc_r(7'h20, 3'b000, 4, 3, 1),
                         enc_r(7'h00, 3'b111, 5, 4, 3), enc_r(7'h00, 3'b110, 6, 5, 1),
                         enc_sw(6, 0, LED)});
        wait_retire(32'd24);
        c = word_t'(a) + word_t'(b);
        d = c - word_t'(a);
        e = (d & c) | word_t'(a);
        check_word(ledr, e, "ALU chain LED value");
    endtask

    task automatic test_load_use();
        load_and_reset('{enc_addi(1, 0, 12'd123), enc_sw(1, 0, 12'd8), enc_lw(2, 0, 12'd8),
                         enc_addi(3, 2, 12'd1), enc_sw(3, 0, LED)});
        wait_retire(32'd16);
        check_word(ledr, 32'd124, "load-use LED value");
        check_trace('{32'd0, 32'd4, 32'd8, 32'd12, 32'd16}, "load-use trace");
    endtask

    task automatic test_branches();
        load_and_reset('{enc_addi(1, 0, 12'd5), enc_addi(2, 0, 12'd5),
                         enc_br(1'b0, 1, 2, 13'd16), enc_addi(4, 0, 12'd99),
                         enc_sw(4, 0, LED), enc_sw(1, 0, LED),
                         enc_br(1'b1, 1, 2, 13'd16), enc_addi(4, 0, 12'd77),
                         enc_sw(4, 0, LED)});
        wait_retire(32'd32);
        check_word(ledr, 32'd77, "branch LED value");
        check_trace('{32'd0, 32'd4, 32'd8, 32'd24, 32'd28, 32'd32}, "branch trace");
    endtask

    task automatic test_jal();
        load_and_reset('{enc_addi(5, 0, 12'd1), enc_jal(1, 21'd16), enc_sw(5, 0, LED),
                         enc_sw(5, 0, LED), enc_sw(5, 0, LED), enc_sw(1, 0, LED)});
        wait_retire(32'd20);
        check_word(ledr, 32'd8, "JAL link value");
        check_trace('{32'd0, 32'd4, 32'd20}, "JAL trace");
    endtask

    task automatic test_reset_illegal();
        load_and_reset('{enc_addi(1, 0, 12'd3), 32'hffff_ffff, enc_addi(1, 1, 12'd4),
                         enc_sw(1, 0, LED)});
        @(negedge clk);
        check_word(word_t'(insn_vld), '0, "retire valid after reset");
        check_word(ledr, '0, "LED after reset");
        wait_retire(32'd12);
        check_word(ledr, 32'd7, "illegal opcode LED value");
        check_trace('{32'd0, 32'd8, 32'd12}, "illegal opcode trace");
    endtask

    initial begin
        #(NUM_TESTS * 200 * 8);
        $display("Timeout: the tests did not finish within the allowed time");
        $display("Regression failed");
        $fatal(1);
    end

    initial begin
        void'($urandom(32'hded10026));
        rst_n = 1'b0;
        foreach (imem[i]) begin
            imem[i] = '0;
        end
        test_alu_forwarding();
        test_load_use();
        test_branches();
        test_jal();
        test_reset_illegal();
        $display("Regression passed");
        $finish;
    end

endmodule

/* src/decode_stage.sv */
module decode_stage (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  pipe_cpu_pkg::if_id_t  if_id_i,
    input  pipe_cpu_pkg::mem_wb_t wb_i,
    input  logic                  flush_i,
    output logic                  stall_o,
    output pipe_cpu_pkg::id_ex_t  id_ex_o
);
    import pipe_cpu_pkg::*;

    insn_u  insn;
    id_ex_t dec;
    logic   legal;
    logic   uses_rs1;
    logic   uses_rs2;
    word_t  regs [32];
    word_t  rs1_rdata;
    word_t  rs2_rdata;

    assign insn = if_id_i.insn;

    // x0 reads zero, a write in flight from MEM/WB is seen at once
    function automatic word_t rf_read(reg_idx_t idx);
        if (idx == '0) begin
            return '0;
        end
        if (wb_i.rd_wren && wb_i.rd == idx) begin
            return wb_i.rd_data;
        end
        return regs[idx];
    endfunction

    always_comb begin
        rs1_rdata = rf_read(insn.r_fmt.rs1);
        rs2_rdata = rf_read(insn.r_fmt.rs2);
    end

    always_ff @(posedge clk_i) begin
        if (wb_i.rd_wren && wb_i.rd != '0) begin
            regs[wb_i.rd] <= wb_i.rd_data;
        end
    end

    always_comb begin
        dec      = '0;
        legal    = 1'b0;
        uses_rs1 = 1'b0;
        uses_rs2 = 1'b0;
        case (insn.r_fmt.opcode)
            OP: begin
                uses_rs1    = 1'b1;
                uses_rs2    = 1'b1;
                dec.rd_wren = 1'b1;
                case (insn.r_fmt.funct3)
                    3'b000: begin
                        legal      = insn.r_fmt.funct7 inside {7'b0000000, 7'b0100000};
                        dec.alu_op = insn.r_fmt.funct7[5] ? ALU_SUB : ALU_ADD;
                    end
                    3'b110: begin
                        legal      = insn.r_fmt.funct7 == 7'b0000000;
                        dec.alu_op = ALU_OR;
                    end
                    3'b111: begin
                        legal      = insn.r_fmt.funct7 == 7'b0000000;
                        dec.alu_op = ALU_AND;
                    end
                    default: legal = 1'b0;
                endcase
            end
            OP_IMM, LOAD: begin
                // ADDI or LW, both add a sign-extended 12-bit offset
                legal        = insn.i_fmt.funct3 == ((insn.i_fmt.opcode == LOAD) ? 3'b010 : 3'b000);
                uses_rs1     = 1'b1;
                dec.use_imm  = 1'b1;
                dec.rd_wren  = 1'b1;
                dec.mem_rden = insn.i_fmt.opcode == LOAD;
                dec.imm      = {{20{insn.i_fmt.imm[11]}}, insn.i_fmt.imm};
            end
            STORE: begin
                legal        = insn.s_fmt.funct3 == 3'b010;
                uses_rs1     = 1'b1;
                uses_rs2     = 1'b1;
                dec.use_imm  = 1'b1;
                dec.mem_wren = 1'b1;
                dec.imm      = {{20{insn.s_fmt.imm_hi[6]}}, insn.s_fmt.imm_hi, insn.s_fmt.imm_lo};
            end
            BRANCH: begin
                legal     = insn.b_fmt.funct3 inside {3'b000, 3'b001};
                uses_rs1  = 1'b1;
                uses_rs2  = 1'b1;
                dec.is_br = 1'b1;
                dec.br_ne = insn.b_fmt.funct3[0];
                dec.imm   = {{19{insn.b_fmt.imm_12}}, insn.b_fmt.imm_12, insn.b_fmt.imm_11,
                             insn.b_fmt.imm_10_5, insn.b_fmt.imm_4_1, 1'b0};
            end
            JAL: begin
                legal       = 1'b1;
                dec.rd_wren = 1'b1;
                dec.is_jal  = 1'b1;
                dec.imm     = {{11{insn.j_fmt.imm_20}}, insn.j_fmt.imm_20, insn.j_fmt.imm_19_12,
                               insn.j_fmt.imm_11, insn.j_fmt.imm_10_1, 1'b0};
            end
            default: legal = 1'b0;
        endcase

        dec.valid = if_id_i.valid && legal;
        // Anything outside the subset passes down as a harmless bubble
        if (!dec.valid) begin
            dec.rd_wren  = 1'b0;
            dec.mem_rden = 1'b0;
            dec.mem_wren = 1'b0;
            dec.is_br    = 1'b0;
            dec.is_jal   = 1'b0;
        end
        dec.pc       = if_id_i.pc;
        dec.rs1      = uses_rs1 ? insn.r_fmt.rs1 : '0;
        dec.rs2      = uses_rs2 ? insn.r_fmt.rs2 : '0;
        dec.rd       = dec.rd_wren ? insn.r_fmt.rd : '0;
        dec.rs1_data = rs1_rdata;
        dec.rs2_data = rs2_rdata;
    end

    // Load in ID/EX feeding the instruction right behind it
    assign stall_o = id_ex_o.valid && id_ex_o.mem_rden && id_ex_o.rd != '0 && dec.valid &&
                     ((dec.rs1 == id_ex_o.rd) || (dec.rs2 == id_ex_o.rd));

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            id_ex_o <= '0;
        end else if (flush_i || stall_o) begin
            id_ex_o <= '0;
        end else begin
            id_ex_o <= dec;
        end
    end

    // The held IF/ID word must be dropped by the flush, not decoded again
    a_no_wr_on_stall_flush: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (stall_o && flush_i) |=> !dec.rd_wren);

endmodule

/* src/execute_stage.sv */
module execute_stage (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  pipe_cpu_pkg::id_ex_t  id_ex_i,
    input  pipe_cpu_pkg::ex_mem_t ex_mem_fb_i,
    input  pipe_cpu_pkg::mem_wb_t wb_i,
    input  logic                  flush_i,
    output pipe_cpu_pkg::ex_mem_t ex_mem_o
);
    import pipe_cpu_pkg::*;

    word_t   ex_fwd_data;
    word_t   opa;
    word_t   opb;
    word_t   rs2_fwd;
    word_t   alu_res;
    logic    taken;
    ex_mem_t nxt;

    // A JAL in EX/MEM writes its link, not the ALU result
    assign ex_fwd_data = ex_mem_fb_i.taken ? ex_mem_fb_i.link : ex_mem_fb_i.alu_data;

    // Youngest producer first, loads in EX/MEM are covered by the stall
    function automatic word_t fwd(reg_idx_t rs, word_t rf_val);
        if (rs == '0) begin
            return rf_val;
        end
        if (ex_mem_fb_i.rd_wren && !ex_mem_fb_i.mem_rden && ex_mem_fb_i.rd == rs) begin
            return ex_fwd_data;
        end
        if (wb_i.rd_wren && wb_i.rd == rs) begin
            return wb_i.rd_data;
        end
        return rf_val;
    endfunction

    always_comb begin
        opa     = fwd(id_ex_i.rs1, id_ex_i.rs1_data);
        rs2_fwd = fwd(id_ex_i.rs2, id_ex_i.rs2_data);
        opb     = id_ex_i.use_imm ? id_ex_i.imm : rs2_fwd;
        case (id_ex_i.alu_op)
            ALU_ADD: alu_res = opa + opb;
            ALU_SUB: alu_res = opa - opb;
            ALU_AND: alu_res = opa & opb;
            ALU_OR:  alu_res = opa | opb;
            default: alu_res = opa + opb;
        endcase
    end

    // BEQ and BNE share the comparator, br_ne flips the sense
    assign taken = id_ex_i.valid &&
                   (id_ex_i.is_jal || (id_ex_i.is_br && ((opa == rs2_fwd) ^ id_ex_i.br_ne)));

    always_comb begin
        nxt           = '0;
        nxt.valid     = id_ex_i.valid;
        nxt.pc        = id_ex_i.pc;
        nxt.rd        = id_ex_i.rd;
        nxt.alu_data  = alu_res;
        nxt.st_data   = rs2_fwd;
        nxt.br_target = id_ex_i.pc + id_ex_i.imm;
        nxt.link      = id_ex_i.pc + 32'd4;
        nxt.rd_wren   = id_ex_i.rd_wren;
        nxt.mem_rden  = id_ex_i.mem_rden;
        nxt.mem_wren  = id_ex_i.mem_wren;
        nxt.taken     = taken;
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            ex_mem_o <= '0;
        end else if (flush_i) begin
            ex_mem_o <= '0;
        end else begin
            ex_mem_o <= nxt;
        end
    end

    a_target_aligned: assert property (@(posedge clk_i) disable iff (!rst_ni)
        ex_mem_o.taken |-> ex_mem_o.br_target[1:0] == 2'b00);

endmodule

/* src/fetch_stage.sv */
module fetch_stage (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    stall_i,
    input  pipe_cpu_pkg::redirect_t redirect_i,
    output pipe_cpu_pkg::word_t     imem_addr_o,
    input  pipe_cpu_pkg::word_t     imem_rdata_i,
    output pipe_cpu_pkg::if_id_t    if_id_o
);
    import pipe_cpu_pkg::*;

    word_t pc_q;
    word_t pc_next;

    assign imem_addr_o = pc_q;

    // Redirect wins over a load-use hold
    always_comb begin
        if (redirect_i.flush) begin
            pc_next = redirect_i.target;
        end else if (stall_i) begin
            pc_next = pc_q;
        end else begin
            pc_next = pc_q + 32'd4;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            pc_q <= '0;
        end else begin
            pc_q <= pc_next;
        end
    end

    // IF/ID register
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            if_id_o <= '0;
        end else if (redirect_i.flush) begin
            if_id_o <= '0;
        end else if (!stall_i) begin
            if_id_o.valid <= 1'b1;
            if_id_o.pc    <= pc_q;
            if_id_o.insn  <= imem_rdata_i;
        end
    end

endmodule

/* src/memory_stage.sv */
module memory_stage #(
    parameter int DMEM_WORDS = 64
) (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  pipe_cpu_pkg::ex_mem_t   ex_mem_i,
    output pipe_cpu_pkg::redirect_t redirect_o,
    output pipe_cpu_pkg::mem_wb_t   mem_wb_o,
    output pipe_cpu_pkg::word_t     io_ledr_o
);
    import pipe_cpu_pkg::*;

    localparam int IDX_W = $clog2(DMEM_WORDS);

    word_t            dmem [DMEM_WORDS];
    logic [IDX_W-1:0] dmem_idx;
    logic             is_led;
    word_t            ld_data;
    word_t            rd_data;

    // Word addressed, upper address bits alias
    assign dmem_idx = ex_mem_i.alu_data[IDX_W+1:2];
    assign is_led   = ex_mem_i.alu_data == LED_ADDR;
    assign ld_data  = is_led ? io_ledr_o : dmem[dmem_idx];

    always_ff @(posedge clk_i) begin
        if (ex_mem_i.mem_wren && !is_led) begin
            dmem[dmem_idx] <= ex_mem_i.st_data;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            io_ledr_o <= '0;
        end else if (ex_mem_i.mem_wren && is_led) begin
            io_ledr_o <= ex_mem_i.st_data;
        end
    end

    // Taken branch or JAL resolves here
    assign redirect_o.flush  = ex_mem_i.valid && ex_mem_i.taken;
    assign redirect_o.target = ex_mem_i.br_target;

    // Only a JAL both writes rd and is taken
    assign rd_data = ex_mem_i.mem_rden ? ld_data :
                     ex_mem_i.taken    ? ex_mem_i.link : ex_mem_i.alu_data;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            mem_wb_o <= '0;
        end else begin
            mem_wb_o.valid   <= ex_mem_i.valid;
            mem_wb_o.pc      <= ex_mem_i.pc;
            mem_wb_o.rd      <= ex_mem_i.rd;
            mem_wb_o.rd_wren <= ex_mem_i.rd_wren;
            mem_wb_o.rd_data <= rd_data;
        end
    end

    a_rd_wr_exclusive: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(ex_mem_i.mem_rden && ex_mem_i.mem_wren));

endmodule

/* src/pipe_cpu.sv */
module pipe_cpu #(
    parameter int DMEM_WORDS = 64
) (
    input  logic                clk_i,
    input  logic                rst_ni,
    output pipe_cpu_pkg::word_t imem_addr_o,
    input  pipe_cpu_pkg::word_t imem_rdata_i,
    output pipe_cpu_pkg::word_t io_ledr_o,
    output pipe_cpu_pkg::word_t pc_debug_o,
    output logic                insn_vld_o
);
    import pipe_cpu_pkg::*;

    if_id_t    if_id;
    id_ex_t    id_ex;
    ex_mem_t   ex_mem;
    mem_wb_t   mem_wb;
    redirect_t redirect;
    logic      stall;

    fetch_stage i_fetch_stage (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .stall_i      (stall),
        .redirect_i   (redirect),
        .imem_addr_o  (imem_addr_o),
        .imem_rdata_i (imem_rdata_i),
        .if_id_o      (if_id)
    );

    decode_stage i_decode_stage (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .if_id_i (if_id),
        .wb_i    (mem_wb),
        .flush_i (redirect.flush),
        .stall_o (stall),
        .id_ex_o (id_ex)
    );

    execute_stage i_execute_stage (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .id_ex_i     (id_ex),
        .ex_mem_fb_i (ex_mem),
        .wb_i        (mem_wb),
        .flush_i     (redirect.flush),
        .ex_mem_o    (ex_mem)
    );

    memory_stage #(
        .DMEM_WORDS (DMEM_WORDS)
    ) i_memory_stage (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .ex_mem_i   (ex_mem),
        .redirect_o (redirect),
        .mem_wb_o   (mem_wb),
        .io_ledr_o  (io_ledr_o)
    );

    // Retire view straight off MEM/WB
    assign pc_debug_o = mem_wb.pc;
    assign insn_vld_o = mem_wb.valid;

endmodule

/* src/pipe_cpu_pkg.sv */
package pipe_cpu_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_idx_t;

    // Stores here drive the red LEDs instead of data memory
    localparam word_t LED_ADDR = 32'h0000_0100;

    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [1:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR
    } alu_op_e;

    // Instruction formats, MSB first
    typedef struct packed {
        logic [6:0] funct7;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        reg_idx_t   rd;
        opcode_e    opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        reg_idx_t    rs1;
        logic [2:0]  funct3;
        reg_idx_t    rd;
        opcode_e     opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        opcode_e    opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        opcode_e    opcode;
    } b_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        reg_idx_t   rd;
        opcode_e    opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        j_fmt_t j_fmt;
    } insn_u;

    typedef struct packed {
        logic  valid;
        word_t pc;
        insn_u insn;
    } if_id_t;

    typedef struct packed {
        logic     valid;
        word_t    pc;
        reg_idx_t rs1;
        reg_idx_t rs2;
        reg_idx_t rd;
        word_t    rs1_data;
        word_t    rs2_data;
        word_t    imm;
        alu_op_e  alu_op;
        logic     use_imm;
        logic     rd_wren;
        logic     mem_rden;
        logic     mem_wren;
        logic     is_br;
        logic     br_ne;
        logic     is_jal;
    } id_ex_t;

    typedef struct packed {
        logic     valid;
        word_t    pc;
        reg_idx_t rd;
        word_t    alu_data;
        word_t    st_data;
        word_t    br_target;
        word_t    link;
        logic     rd_wren;
        logic     mem_rden;
        logic     mem_wren;
        logic     taken;
    } ex_mem_t;

    typedef struct packed {
        logic     valid;
        word_t    pc;
        reg_idx_t rd;
        logic     rd_wren;
        word_t    rd_data;
    } mem_wb_t;

    typedef struct packed {
        logic  flush;
        word_t target;
    } redirect_t;

endpackage
